// File: build.f
hw/spi_pkg.sv
hw/spi_cmd_stage.sv
hw/spi_bit_timer.sv
hw/spi_shifter.sv
hw/spi_read_stage.sv
hw/spi_master.sv
dv/spi_checker.sv
dv/tb_top.sv

// File: Makefile
# Verilator flow for the SPI master testbench.

TOP = tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f hw/*.sv dv/*.sv
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: dv/tb_top.sv
`timescale 1ns/10ps

module tb_top;

  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int CLK_DIV    = 4;
  localparam int SEED       = 46425;
  localparam int NUM_CMDS   = 200;
  localparam int MAX_CYCLES = NUM_CMDS * (2 * CLK_DIV * CMD_WIDTH + 40) * 2;

  logic                    clk;
  logic                    rst_n;
  logic [CMD_WIDTH-1:0]    cmd_in;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic                    sclk;
  logic                    cs;
  logic                    mosi;
  logic                    miso;
  logic                    read_vld;
  logic [READ_WIDTH-1:0]   read_data;
  logic [8*READ_WIDTH-1:0] init_regs;
  int                      error_count;
  int                      frame_count;
  int                      accept_count;
  int                      test_count;
  logic                    read_pending;

  // slave register file and its frame decoder.
  logic [READ_WIDTH-1:0] slave_regs [8];
  logic [CMD_WIDTH-1:0]  sl_shift;
  logic                  sl_op;
  logic [2:0]            sl_addr;
  int                    sl_cnt;
  int                    cycles;

  spi_master #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH),
    .CLK_DIV    (CLK_DIV)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_checker #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH)
  ) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_in       (cmd_in),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .cs           (cs),
    .sclk         (sclk),
    .mosi         (mosi),
    .read_vld     (read_vld),
    .read_data    (read_data),
    .init_regs    (init_regs),
    .error_count  (error_count),
    .frame_count  (frame_count),
    .accept_count (accept_count),
    .test_count   (test_count),
    .read_pending (read_pending)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  always @(negedge cs)
  begin
    sl_cnt   = 0;
    sl_shift = '0;
    sl_op    = 1'b1;
  end

  always @(posedge sclk)
  begin
    if (!cs)
    begin
      sl_shift = {sl_shift[CMD_WIDTH-2:0], mosi};
      sl_cnt++;
      if (sl_cnt == CMD_WIDTH - READ_WIDTH)
      begin
        sl_op   = sl_shift[CMD_WIDTH-READ_WIDTH-1];
        sl_addr = sl_shift[2:0];
      end
      if (sl_cnt == CMD_WIDTH && sl_op)
      begin
        slave_regs[sl_shift[CMD_WIDTH-2 -: 3]] = sl_shift[READ_WIDTH-1:0];
      end
    end
  end

  // the addressed byte goes out MSB first, one bit per falling edge.
  always @(negedge sclk)
  begin
    if (!cs && !sl_op && sl_cnt >= CMD_WIDTH - READ_WIDTH && sl_cnt < CMD_WIDTH)
    begin
      miso = slave_regs[sl_addr][CMD_WIDTH - 1 - sl_cnt];
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic send_command(input logic [CMD_WIDTH-1:0] word);
    int   gap;
    logic taken;
    gap = $urandom % 4;
    repeat (gap) @(negedge clk);
    cmd_in  = word;
    cmd_vld = 1'b1;
    taken   = 1'b0;
    while (!taken)
    begin
      taken = cmd_rdy;
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    cmd_in  = CMD_WIDTH'($urandom);
  endtask

  initial
  begin
    logic [CMD_WIDTH-1:0] word;
    int                   end_errors;
    void'($urandom(SEED));
    cycles     = 0;
    end_errors = 0;
    rst_n      = 1'b0;
    cmd_vld    = 1'b0;
    cmd_in     = '0;
    miso       = 1'b0;
    sl_cnt     = 0;
    sl_op      = 1'b1;
    sl_addr    = '0;
    sl_shift   = '0;
    for (int k = 0; k < 8; k++)
    begin
      slave_regs[k] = READ_WIDTH'($urandom);
      init_regs[k*READ_WIDTH +: READ_WIDTH] = slave_regs[k];
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < NUM_CMDS; n++)
    begin
      word = CMD_WIDTH'($urandom);
      send_command(word);
    end
    // the last frame is over once cmd_rdy is back.
    while (!cmd_rdy) @(negedge clk);
    repeat (4) @(negedge clk);
    if (read_pending)
    begin
      $display("error: the last read frame never produced read_vld");
      end_errors++;
    end
    if (frame_count != NUM_CMDS || accept_count != NUM_CMDS)
    begin
      $display("error: expected %0d frames and commands, saw %0d frames, %0d accepted",
               NUM_CMDS, frame_count, accept_count);
      end_errors++;
    end
    $display("tests %0d, frames %0d, accepted %0d, errors %0d",
             test_count, frame_count, accept_count, error_count + end_errors);
    if (error_count + end_errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/spi_checker.sv
`timescale 1ns/10ps

module spi_checker #(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [CMD_WIDTH-1:0]    cmd_in,
  input  logic                    cmd_vld,
  input  logic                    cmd_rdy,
  input  logic                    cs,
  input  logic                    sclk,
  input  logic                    mosi,
  input  logic                    read_vld,
  input  logic [READ_WIDTH-1:0]   read_data,
  input  logic [8*READ_WIDTH-1:0] init_regs,
  output int                      error_count,
  output int                      frame_count,
  output int                      accept_count,
  output int                      test_count,
  output logic                    read_pending
);

  localparam int HDR_W = CMD_WIDTH - READ_WIDTH;

  logic [READ_WIDTH-1:0] shadow [8];
  logic [CMD_WIDTH-1:0]  expect_q [$];
  logic [CMD_WIDTH-1:0]  cap;
  logic [READ_WIDTH-1:0] exp_data;
  logic [2:0]            rd_addr;
  logic                  cs_q;
  logic                  sclk_q;
  logic                  reset_seen;
  int                    rise_cnt;
  int                    err_base;

  initial
  begin
    error_count  = 0;
    frame_count  = 0;
    accept_count = 0;
    test_count   = 0;
    read_pending = 1'b0;
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic report_test(input string what);
    test_count++;
    if (error_count > err_base)
    begin
      $display("test %0d %s: FAILED", test_count, what);
    end
    else
    begin
      $display("test %0d %s: ok", test_count, what);
    end
    err_base = error_count;
  endtask

  // closes a frame when cs rises and compares it with the oldest accepted command.
  task automatic finish_frame();
    logic [CMD_WIDTH-1:0] cmd;
    logic [2:0]           addr;
    frame_count++;
    if (expect_q.size() == 0)
    begin
      $display("error at %0t: a frame ran without an accepted command", $time);
      error_count++;
      return;
    end
    cmd  = expect_q.pop_front();
    addr = cmd[CMD_WIDTH-2 -: 3];
    if (rise_cnt != CMD_WIDTH)
    begin
      $display("mismatch at %0t: sclk_rises expected %0d actual %0d",
               $time, CMD_WIDTH, rise_cnt);
      error_count++;
    end
    if (cmd[CMD_WIDTH-1])
    begin
      if (cap !== cmd)
      begin
        $display("mismatch at %0t: mosi expected %h actual %h", $time, cmd, cap);
        error_count++;
      end
      shadow[addr] = cmd[READ_WIDTH-1:0];
      report_test($sformatf("write addr %0d", addr));
    end
    else
    begin
      if (cap[CMD_WIDTH-1 -: HDR_W] !== cmd[CMD_WIDTH-1 -: HDR_W])
      begin
        $display("mismatch at %0t: mosi_header expected %h actual %h", $time,
                 cmd[CMD_WIDTH-1 -: HDR_W], cap[CMD_WIDTH-1 -: HDR_W]);
        error_count++;
      end
      if (cap[READ_WIDTH-1:0] !== '0)
      begin
        $display("mismatch at %0t: mosi_read_phase expected %h actual %h", $time,
                 {READ_WIDTH{1'b0}}, cap[READ_WIDTH-1:0]);
        error_count++;
      end
      exp_data     = shadow[addr];
      rd_addr      = addr;
      read_pending = 1'b1;
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int k = 0; k < 8; k++)
      begin
        shadow[k] = init_regs[k*READ_WIDTH +: READ_WIDTH];
      end
      cs_q         = 1'b1;
      sclk_q       = 1'b0;
      reset_seen   = 1'b0;
      read_pending = 1'b0;
      err_base     = error_count;
    end
    else
    begin
      if (!reset_seen)
      begin
        reset_seen = 1'b1;
        check_bit("cmd_rdy", 1'b1, cmd_rdy);
        check_bit("cs", 1'b1, cs);
        check_bit("sclk", 1'b0, sclk);
        check_bit("read_vld", 1'b0, read_vld);
        report_test("reset state");
      end
      if (cs && sclk)
      begin
        $display("error at %0t: sclk is high while cs is high", $time);
        error_count++;
      end
      if (cmd_vld && cmd_rdy)
      begin
        expect_q.push_back(cmd_in);
        accept_count++;
      end
      if (cs_q && !cs)
      begin
        if (read_pending)
        begin
          $display("error at %0t: a read frame ended without a read_vld pulse", $time);
          error_count++;
          read_pending = 1'b0;
          report_test($sformatf("read addr %0d", rd_addr));
        end
        rise_cnt = 0;
        cap      = '0;
      end
      if (!cs && sclk && !sclk_q)
      begin
        cap = {cap[CMD_WIDTH-2:0], mosi};
        rise_cnt++;
      end
      if (read_vld)
      begin
        if (!read_pending)
        begin
          $display("error at %0t: read_vld pulsed without a pending read", $time);
          error_count++;
        end
        else
        begin
          if (read_data !== exp_data)
          begin
            $display("mismatch at %0t: read_data expected %h actual %h",
                     $time, exp_data, read_data);
            error_count++;
          end
          read_pending = 1'b0;
          report_test($sformatf("read addr %0d", rd_addr));
        end
      end
      if (!cs_q && cs)
      begin
        finish_frame();
      end
      cs_q   = cs;
      sclk_q = sclk;
    end
  end

endmodule

// File: hw/spi_master.sv
`timescale 1ns/10ps

module spi_master #(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8,
  parameter int CLK_DIV    = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  logic                 start;
  logic [CMD_WIDTH-1:0] cmd_word;
  spi_pkg::spi_op_e     op;
  logic                 run;
  logic                 sample;
  logic                 launch;
  logic                 read_phase;
  logic                 done;

  spi_cmd_stage #(
    .CMD_WIDTH (CMD_WIDTH)
  ) u_cmd_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .done     (done),
    .cmd_rdy  (cmd_rdy),
    .start    (start),
    .cmd_word (cmd_word),
    .op       (op)
  );

  spi_bit_timer #(
    .CLK_DIV (CLK_DIV)
  ) u_bit_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .run    (run),
    .sample (sample),
    .launch (launch)
  );

  spi_shifter #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH)
  ) u_shifter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cmd_word   (cmd_word),
    .op         (op),
    .sample     (sample),
    .launch     (launch),
    .run        (run),
    .read_phase (read_phase),
    .done       (done),
    .cs         (cs),
    .sclk       (sclk),
    .mosi       (mosi)
  );

  spi_read_stage #(
    .READ_WIDTH (READ_WIDTH)
  ) u_read_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .miso       (miso),
    .sample     (sample),
    .read_phase (read_phase),
    .done       (done),
    .op         (op),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

endmodule

// File: hw/spi_read_stage.sv
`timescale 1ns/10ps

module spi_read_stage #(
  parameter int READ_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  miso,
  input  logic                  sample,
  input  logic                  read_phase,
  input  logic                  done,
  input  spi_pkg::spi_op_e      op,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  logic [READ_WIDTH-1:0] cap;
  logic                  publish;

  // a write frame never produces a result.
  assign publish = done && (op == spi_pkg::OP_READ);

  // bits arrive MSB first, so they enter at the bottom and move up.
  always_ff @(posedge clk)
  begin
    if (sample && read_phase)
    begin
      cap <= {cap[READ_WIDTH-2:0], miso};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= publish;
      if (publish)
      begin
        read_data <= cap;
      end
    end
  end

endmodule

// File: hw/spi_shifter.sv
`timescale 1ns/10ps

module spi_shifter #(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic [CMD_WIDTH-1:0] cmd_word,
  input  spi_pkg::spi_op_e     op,
  input  logic                 sample,
  input  logic                 launch,
  output logic                 run,
  output logic                 read_phase,
  output logic                 done,
  output logic                 cs,
  output logic                 sclk,
  output logic                 mosi
);

  localparam int CW = $clog2(CMD_WIDTH);
  localparam logic [CW-1:0] LAST_BIT = CW'(CMD_WIDTH - 1);
  // first bit index that belongs to the data returned by the slave.
  localparam logic [CW-1:0] RD_FIRST = CW'(CMD_WIDTH - READ_WIDTH);

  spi_pkg::spi_phase_e  phase;
  logic [CW-1:0]        bit_cnt;
  logic [CW-1:0]        next_cnt;
  logic [CMD_WIDTH-1:0] shreg;
  logic                 is_read;

  assign is_read    = (op == spi_pkg::OP_READ);
  assign next_cnt   = bit_cnt + 1'b1;
  assign run        = (phase == spi_pkg::PH_SHIFT);
  assign done       = (phase == spi_pkg::PH_DONE);
  assign read_phase = run && is_read && (bit_cnt >= RD_FIRST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase   <= spi_pkg::PH_IDLE;
      bit_cnt <= '0;
      cs      <= 1'b1;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
    end
    else
    begin
      case (phase)
        spi_pkg::PH_IDLE:
        begin
          if (start)
          begin
            phase   <= spi_pkg::PH_SETUP;
            bit_cnt <= '0;
            cs      <= 1'b0;
            mosi    <= cmd_word[CMD_WIDTH-1];
          end
        end
        spi_pkg::PH_SETUP:
        begin
          phase <= spi_pkg::PH_SHIFT;
        end
        spi_pkg::PH_SHIFT:
        begin
          if (sample)
          begin
            sclk <= 1'b1;
          end
          else if (launch)
          begin
            sclk <= 1'b0;
            if (bit_cnt == LAST_BIT)
            begin
              phase <= spi_pkg::PH_DONE;
              cs    <= 1'b1;
              mosi  <= 1'b0;
            end
            else
            begin
              bit_cnt <= next_cnt;
              // while the slave answers a read, mosi stays low.
              if (is_read && (next_cnt >= RD_FIRST))
              begin
                mosi <= 1'b0;
              end
              else
              begin
                mosi <= shreg[CMD_WIDTH-1];
              end
            end
          end
        end
        default:
        begin
          phase <= spi_pkg::PH_IDLE;
        end
      endcase
    end
  end

  // shreg keeps the next bit to send in its top position.
  always_ff @(posedge clk)
  begin
    if ((phase == spi_pkg::PH_IDLE) && start)
    begin
      shreg <= {cmd_word[CMD_WIDTH-2:0], 1'b0};
    end
    else if (run && launch)
    begin
      shreg <= {shreg[CMD_WIDTH-2:0], 1'b0};
    end
  end

endmodule

// File: hw/spi_bit_timer.sv
`timescale 1ns/10ps

module spi_bit_timer #(
  parameter int CLK_DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sample,
  output logic launch
);

  localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLK_DIV - 1);

  logic [CNT_W-1:0] cnt;
  logic             half;
  logic             tick;

  // a tick marks the last clk of a half-period.
  assign tick = run && (cnt == '0);

  // the first half-period ends on the sclk rising point.
  assign sample = tick && !half;
  assign launch = tick && half;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt  <= RELOAD;
      half <= 1'b0;
    end
    else if (!run)
    begin
      cnt  <= RELOAD;
      half <= 1'b0;
    end
    else if (tick)
    begin
      cnt  <= RELOAD;
      half <= ~half;
    end
    else
    begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

// File: hw/spi_cmd_stage.sv
`timescale 1ns/10ps

module spi_cmd_stage #(
  parameter int CMD_WIDTH = 12
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 done,
  output logic                 cmd_rdy,
  output logic                 start,
  output logic [CMD_WIDTH-1:0] cmd_word,
  output spi_pkg::spi_op_e     op
);

  logic accept;

  // a command is taken only while no frame is in flight.
  assign accept = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_rdy <= 1'b1;
      start   <= 1'b0;
      op      <= spi_pkg::OP_READ;
    end
    else
    begin
      start <= 1'b0;
      if (accept)
      begin
        cmd_rdy <= 1'b0;
        start   <= 1'b1;
        if (cmd_in[CMD_WIDTH-1])
        begin
          op <= spi_pkg::OP_WRITE;
        end
        else
        begin
          op <= spi_pkg::OP_READ;
        end
      end
      else if (done)
      begin
        // the shifter has closed the frame, so the next command may come in.
        cmd_rdy <= 1'b1;
      end
    end
  end

  // the word stays put for the whole frame, it only changes on acceptance.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_word <= cmd_in;
    end
  end

endmodule

// File: hw/spi_pkg.sv
package spi_pkg;

  // operation carried in the top bit of a command word.
  // a set top bit asks for a write, a clear one for a read.
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  // phases of the frame sequencer.
  // PH_IDLE waits for a start with cs high and sclk low.
  // PH_SETUP has cs low and the first bit on mosi, one clk before the timer runs.
  // PH_SHIFT runs the bit timer and moves one bit per sclk period.
  // PH_DONE has cs high again and signals the end of the frame for one clk.
  typedef enum logic [1:0]
  {
    PH_IDLE  = 2'd0,
    PH_SETUP = 2'd1,
    PH_SHIFT = 2'd2,
    PH_DONE  = 2'd3
  } spi_phase_e;

endpackage
